// ==== design/bus_pkg.sv ====
/*
 * Native memory bus types of the RISC-V core
 * Packed forward and return channels plus the responder FSM and access kinds
 */

package bus_pkg;

    // ------------------------------
    // Bus channels
    // ------------------------------

    // Master to slave, 69 bits
    typedef struct packed {
        logic        valid;  // Held until ready
        logic [31:0] addr;   // Byte address
        logic [31:0] wdata;  // Write data
        logic [3:0]  wstrb;  // Byte enables, all zero on a read
    } mem_fwd_t;

    // Slave to master, 33 bits
    typedef struct packed {
        logic        ready;  // One-cycle acknowledge
        logic [31:0] rdata;  // Valid while ready is high
    } mem_ret_t;

    // ------------------------------
    // Responder types
    // ------------------------------

    typedef enum logic {
        SFR_IDLE,  // Waiting for a valid that hits
        SFR_ACK    // Ready cycle
    } sfr_state_e;

    // Write when any wstrb bit is set
    typedef enum logic {
        ACC_READ,
        ACC_WRITE
    } access_e;

endpackage

// ==== design/delay_pkg.sv ====
/*
 * Delay line definitions
 * Tap range, byte layout of the control register and its packed view
 */

package delay_pkg;

    // ------------------------------
    // Tap range
    // ------------------------------

    localparam int TAP_W   = 5;   // Tap value width
    localparam int MAX_TAP = 31;  // Largest tap, chain is MAX_TAP+1 deep

    // ------------------------------
    // Control register layout
    // ------------------------------

    localparam int SEL_W    = 8;   // Channel index width
    localparam int RSVD_W   = 32 - 1 - TAP_W - SEL_W;  // 18 reserved bits
    localparam int TAP_BYTE = 1;   // Byte lane that carries the tap field

    // Single register at word 0 of the window
    //   31    rdy, read only
    //   30:13 reserved, read as zero
    //   12:8  tap
    //   7:0   sel
    typedef struct packed {
        logic              rdy;       // Calibration done
        logic [RSVD_W-1:0] reserved;  // Zero on readback
        logic [TAP_W-1:0]  tap;       // Tap to load, or tap in use on readback
        logic [SEL_W-1:0]  sel;       // Channel index
    } ctrl_reg_t;

endpackage

// ==== design/sfr_regs.sv ====
/*
 * Special function register block
 * Decodes the address window, acknowledges each hit with a single ready cycle,
 * keeps N_REGS byte-writable words and pulses per-byte write strobes
 */

module sfr_regs #(
    parameter logic [7:0] BASE_ADDR  = 8'h00,
    parameter logic [7:0] BASE2_ADDR = 8'h00,
    parameter int         N_REGS     = 1
) (
    input  logic                    clk,
    input  logic                    rst,
    input  bus_pkg::mem_fwd_t       mem_fwd,
    output bus_pkg::mem_ret_t       mem_ret,
    output logic [N_REGS-1:0][31:0] regs_out,  // Stored register contents
    input  logic [N_REGS-1:0][31:0] regs_in,   // Readback words
    output logic [N_REGS-1:0][3:0]  wr_str     // Byte strobes, pulse in ACK cycle
);

    localparam int IDX_W = (N_REGS > 1) ? $clog2(N_REGS) : 1;

    bus_pkg::sfr_state_e     state_q;
    bus_pkg::access_e        acc_q;    // Kind of the access in flight
    logic [IDX_W-1:0]        idx_q;    // Word being acknowledged
    logic [3:0]              strb_q;   // Its byte enables
    logic                    held_q;   // Valid still held after an ACK
    logic [N_REGS-1:0][31:0] regs_q;
    logic                    hit;
    logic                    start;
    logic                    ack;
    logic [IDX_W-1:0]        idx_new;

    // ------------------------------
    // Address decode
    // ------------------------------

    assign hit = (mem_fwd.addr[31:24] == BASE_ADDR) &&
                 (mem_fwd.addr[23:16] == BASE2_ADDR) &&
                 (int'(mem_fwd.addr[15:2]) < N_REGS);

    assign idx_new = mem_fwd.addr[2 +: IDX_W];

    // A held valid must drop before it can open another access
    assign start = (state_q == bus_pkg::SFR_IDLE) && mem_fwd.valid && hit && !held_q;

    // ------------------------------
    // Responder FSM
    // ------------------------------

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= bus_pkg::SFR_IDLE;
            acc_q   <= bus_pkg::ACC_READ;
            idx_q   <= '0;
            strb_q  <= '0;
            held_q  <= 1'b0;
        end else begin
            case (state_q)
                bus_pkg::SFR_IDLE: begin
                    if (start) begin
                        state_q <= bus_pkg::SFR_ACK;
                        idx_q   <= idx_new;
                        strb_q  <= mem_fwd.wstrb;
                        acc_q   <= (|mem_fwd.wstrb) ? bus_pkg::ACC_WRITE : bus_pkg::ACC_READ;
                    end
                end
                bus_pkg::SFR_ACK: state_q <= bus_pkg::SFR_IDLE;  // Always a single cycle
                default:          state_q <= bus_pkg::SFR_IDLE;
            endcase
            if (state_q == bus_pkg::SFR_ACK)
                held_q <= mem_fwd.valid;  // Master did not let go yet
            else if (!mem_fwd.valid)
                held_q <= 1'b0;           // Rearm once valid is low
        end
    end

    // Write data lands on the edge that enters ACK, so the strobe cycle
    // already sees the new contents
    always_ff @(posedge clk) begin
        if (rst) begin
            regs_q <= '0;
        end else if (start) begin
            for (int b = 0; b < 4; b++) begin
                if (mem_fwd.wstrb[b])
                    regs_q[idx_new][8*b +: 8] <= mem_fwd.wdata[8*b +: 8];
            end
        end
    end

    assign regs_out = regs_q;
    assign ack      = (state_q == bus_pkg::SFR_ACK);

    // ------------------------------
    // Return channel and strobes
    // ------------------------------

    always_comb begin
        wr_str        = '0;
        mem_ret.ready = ack;
        mem_ret.rdata = '0;                 // Zero outside the ACK cycle
        if (ack) begin
            mem_ret.rdata = regs_in[idx_q];
            if (acc_q == bus_pkg::ACC_WRITE)
                wr_str[idx_q] = strb_q;
        end
    end

    // Acknowledge is a pulse, never a level
    a_ready_pulse: assert property (@(posedge clk) disable iff (rst)
        mem_ret.ready |=> !mem_ret.ready);

    // Strobes only inside an acknowledged access
    a_str_in_ack: assert property (@(posedge clk) disable iff (rst)
        (|wr_str) |-> mem_ret.ready);

endmodule

// ==== design/tap_delay_line.sv ====
/*
 * Single delay channel
 * Input runs through MAX_TAP+1 sample stages, the tap register picks the
 * stage, the output stays low until enable is raised
 */

module tap_delay_line (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      in,       // Undelayed input bit
    input  logic                      load,     // Take tap_in on the next edge
    input  logic [delay_pkg::TAP_W-1:0] tap_in,
    output logic [delay_pkg::TAP_W-1:0] tap_mon, // Tap in use
    input  logic                      enable,   // Calibration done
    output logic                      out_del
);

    logic [delay_pkg::MAX_TAP:0]   chain_q;  // Stage k holds in from k+1 edges ago
    logic [delay_pkg::TAP_W-1:0]   tap_q;

    // ------------------------------
    // Sample chain
    // ------------------------------

    // Pure data path, filled long before enable rises
    always_ff @(posedge clk) begin
        chain_q <= {chain_q[delay_pkg::MAX_TAP-1:0], in};
    end

    // ------------------------------
    // Tap register
    // ------------------------------

    always_ff @(posedge clk) begin
        if (rst)
            tap_q <= '0;          // Tap 0 after reset
        else if (load)
            tap_q <= tap_in;
    end

    assign tap_mon = tap_q;

    // Stage select, gated by calibration
    assign out_del = enable ? chain_q[tap_q] : 1'b0;

    // The bank must not issue loads while reset is held
    a_no_load_in_rst: assert property (@(posedge clk)
        rst |-> !load);

endmodule

// ==== design/delay_calib.sv ====
/*
 * Calibration ready model
 * Counts clock edges after reset and reports the delay lines as ready
 */

module delay_calib #(
    parameter int CALIB_CYCLES = 20
) (
    input  logic clk,
    input  logic rst,
    output logic rdy
);

    localparam int CNT_W = (CALIB_CYCLES > 0) ? $clog2(CALIB_CYCLES + 1) : 1;

    logic [CNT_W-1:0] cnt_q;

    // Saturating count of edges since reset release
    always_ff @(posedge clk) begin
        if (rst)
            cnt_q <= '0;
        else if (!rdy)
            cnt_q <= cnt_q + 1'b1;  // Stops at CALIB_CYCLES
    end

    assign rdy = (cnt_q == CNT_W'(CALIB_CYCLES));

    // Ready is sticky until the next reset
    a_rdy_sticky: assert property (@(posedge clk) disable iff (rst)
        rdy |=> rdy);

endmodule

// ==== design/delay_bank.sv ====
/*
 * Bus-controlled bank of delay channels
 * One control register selects a channel, loads its tap and reads back the
 * tap in use together with the calibration flag
 */

module delay_bank #(
    parameter logic [7:0] BASE_ADDR  = 8'h00,
    parameter logic [7:0] BASE2_ADDR = 8'h00,
    parameter int         SIZE       = 1      // 1 to 255 channels
) (
    input  logic              clk,
    input  logic              rst,
    input  bus_pkg::mem_fwd_t mem_fwd,
    output bus_pkg::mem_ret_t mem_ret,
    input  logic              rdy,      // From the calibration stage
    input  logic [SIZE-1:0]   in,
    output logic [SIZE-1:0]   out_del
);

    logic [0:0][31:0]                   regs_out;
    logic [0:0][31:0]                   regs_in;
    logic [0:0][3:0]                    wr_str;
    delay_pkg::ctrl_reg_t               ctrl;     // Stored register view
    delay_pkg::ctrl_reg_t               rd_word;  // Readback view
    logic                               tap_wr;   // Tap byte written
    logic [SIZE-1:0]                    load;     // One-hot channel load
    logic [SIZE-1:0][delay_pkg::TAP_W-1:0] tap_mon;
    logic [delay_pkg::TAP_W-1:0]        rd_tap;

    sfr_regs #(
        .BASE_ADDR  (BASE_ADDR),
        .BASE2_ADDR (BASE2_ADDR),
        .N_REGS     (1)
    ) u_sfr (
        .clk      (clk),
        .rst      (rst),
        .mem_fwd  (mem_fwd),
        .mem_ret  (mem_ret),
        .regs_out (regs_out),
        .regs_in  (regs_in),
        .wr_str   (wr_str)
    );

    // ------------------------------
    // Load decode
    // ------------------------------

    assign ctrl   = delay_pkg::ctrl_reg_t'(regs_out[0]);
    assign tap_wr = wr_str[0][delay_pkg::TAP_BYTE];  // Byte 1 holds the tap

    // Sel beyond the bank matches no channel
    always_comb begin
        for (int i = 0; i < SIZE; i++)
            load[i] = tap_wr && (ctrl.sel == delay_pkg::SEL_W'(i));
    end

    // ------------------------------
    // Readback
    // ------------------------------

    always_comb begin
        rd_tap = '0;                  // Out-of-range sel reads tap 0
        for (int i = 0; i < SIZE; i++) begin
            if (ctrl.sel == delay_pkg::SEL_W'(i))
                rd_tap = tap_mon[i];
        end
        rd_word          = '0;
        rd_word.rdy      = rdy;
        rd_word.tap      = rd_tap;
        rd_word.sel      = ctrl.sel;  // Echo of the stored index
    end

    assign regs_in[0] = rd_word;

    // ------------------------------
    // Channels
    // ------------------------------

    for (genvar i = 0; i < SIZE; i++) begin : g_ch
        tap_delay_line u_line (
            .clk     (clk),
            .rst     (rst),
            .in      (in[i]),
            .load    (load[i]),
            .tap_in  (ctrl.tap),
            .tap_mon (tap_mon[i]),
            .enable  (rdy),
            .out_del (out_del[i])
        );
    end

    // A write reaches at most one channel
    a_load_onehot: assert property (@(posedge clk) disable iff (rst)
        $onehot0(load));

endmodule

// ==== design/delay_ctrl_top.sv ====
/*
 * Delay controller top level
 * Calibration stage gating a bus-controlled bank of delay channels
 */

module delay_ctrl_top #(
    parameter logic [7:0] BASE_ADDR    = 8'h00,
    parameter logic [7:0] BASE2_ADDR   = 8'h00,
    parameter int         SIZE         = 1,   // Channel count
    parameter int         CALIB_CYCLES = 20   // Edges from reset release to ready
) (
    input  logic              clk,
    input  logic              rst,
    input  bus_pkg::mem_fwd_t mem_fwd,
    output bus_pkg::mem_ret_t mem_ret,
    input  logic [SIZE-1:0]   in,
    output logic [SIZE-1:0]   out_del
);

    logic rdy;  // Delay lines calibrated

    delay_calib #(
        .CALIB_CYCLES (CALIB_CYCLES)
    ) u_calib (
        .clk (clk),
        .rst (rst),
        .rdy (rdy)
    );

    delay_bank #(
        .BASE_ADDR  (BASE_ADDR),
        .BASE2_ADDR (BASE2_ADDR),
        .SIZE       (SIZE)
    ) u_bank (
        .clk     (clk),
        .rst     (rst),
        .mem_fwd (mem_fwd),
        .mem_ret (mem_ret),
        .rdy     (rdy),
        .in      (in),
        .out_del (out_del)
    );

endmodule

// ==== verif/tb_delay_checker.sv ====
/*
 * Testbench checker for the delay controller
 * Reference models of calibration, taps and delays plus bus protocol
 * assertions, each keeping its own failure count
 */

module tb_delay_checker #(
    parameter logic [7:0] BASE_ADDR    = 8'h00,
    parameter logic [7:0] BASE2_ADDR   = 8'h00,
    parameter int         SIZE         = 1,
    parameter int         CALIB_CYCLES = 20
) (
    input  logic              clk,
    input  logic              rst,
    input  bus_pkg::mem_fwd_t mem_fwd,
    input  bus_pkg::mem_ret_t mem_ret,
    input  logic [SIZE-1:0]   in,
    input  logic [SIZE-1:0]   out_del,
    output int                errors    // Sum of all assertion failures
);
    timeunit 1ns;
    timeprecision 1ps;

    int                                  cal_cnt = 0;     // Edges since reset release
    bit                                  armed   = 1'b0;  // Reset has been seen once
    bit                                  held    = 1'b0;  // Valid kept after its ready
    bit [31:0]                           ref_reg = '0;
    bit [SIZE-1:0][delay_pkg::TAP_W-1:0] ref_tap = '0;
    bit [SIZE-1:0][delay_pkg::MAX_TAP:0] hist    = '0;    // Bit 0 is the newest sample
    logic                                hit;
    logic                                exp_rdy;
    delay_pkg::ctrl_reg_t                cur;
    delay_pkg::ctrl_reg_t                exp_word;  // Expected read data
    logic [SIZE-1:0]                     exp_out;
    int                                  n_ack   = 0;
    int                                  n_pulse = 0;
    int                                  n_cause = 0;
    int                                  n_held  = 0;
    int                                  n_rst   = 0;
    int                                  n_read  = 0;
    int                                  n_delay = 0;

    // ------------------------------
    // Reference models
    // ------------------------------

    assign hit = (mem_fwd.addr[31:24] == BASE_ADDR) &&
                 (mem_fwd.addr[23:16] == BASE2_ADDR) &&
                 (mem_fwd.addr[15:2] == '0);          // One register only
    assign exp_rdy = (cal_cnt == CALIB_CYCLES);

    always @(posedge clk) begin
        logic [31:0] nxt;
        nxt = ref_reg;
        for (int b = 0; b < 4; b++) begin
            if (mem_fwd.wstrb[b])
                nxt[8*b +: 8] = mem_fwd.wdata[8*b +: 8];  // Byte-masked merge
        end
        armed <= armed | rst;
        if (rst) begin
            cal_cnt <= 0;
            ref_reg <= '0;
            ref_tap <= '0;
            held    <= 1'b0;
        end else begin
            if (cal_cnt < CALIB_CYCLES)
                cal_cnt <= cal_cnt + 1;
            held <= mem_fwd.valid && (held || mem_ret.ready);
            if (mem_ret.ready && hit && (|mem_fwd.wstrb)) begin
                ref_reg <= nxt;
                for (int i = 0; i < SIZE; i++) begin
                    if (mem_fwd.wstrb[1] && (int'(nxt[7:0]) == i))
                        ref_tap[i] <= nxt[12:8];    // Tap in use from the next edge
                end
            end
        end
        for (int i = 0; i < SIZE; i++)
            hist[i] <= {hist[i][delay_pkg::MAX_TAP-1:0], in[i]};
    end

    always_comb begin
        cur          = delay_pkg::ctrl_reg_t'(ref_reg);
        exp_word     = '0;
        exp_word.rdy = exp_rdy;
        exp_word.sel = cur.sel;
        for (int i = 0; i < SIZE; i++) begin
            if (int'(cur.sel) == i)
                exp_word.tap = ref_tap[i];      // Out of range stays zero
            exp_out[i] = exp_rdy && hist[i][ref_tap[i]];
        end
    end

    // ------------------------------
    // Bus protocol
    // ------------------------------

    a_ack_next: assert property (@(posedge clk) disable iff (rst)
        ($rose(mem_fwd.valid) && hit) |=> mem_ret.ready)
        else begin
            n_ack++;
            $display("ready missing one cycle after valid at %0t", $time);
        end

    a_ready_pulse: assert property (@(posedge clk) disable iff (rst)
        mem_ret.ready |=> !mem_ret.ready)
        else begin
            n_pulse++;
            $display("ready lasted more than one cycle at %0t", $time);
        end

    a_ready_cause: assert property (@(posedge clk) disable iff (rst)
        mem_ret.ready |-> (mem_fwd.valid && hit))
        else begin
            n_cause++;
            $display("ready without a valid access in the window at %0t", $time);
        end

    a_no_second: assert property (@(posedge clk) disable iff (rst)
        (held && mem_fwd.valid) |-> !mem_ret.ready)
        else begin
            n_held++;
            $display("held valid got a second ready at %0t", $time);
        end

    a_rst_quiet: assert property (@(posedge clk)
        (armed && rst) |-> !mem_ret.ready)
        else begin
            n_rst++;
            $display("ready raised during reset at %0t", $time);
        end

    // ------------------------------
    // Data against the models
    // ------------------------------

    a_read: assert property (@(posedge clk) disable iff (rst)
        (mem_ret.ready && (mem_fwd.wstrb == '0)) |-> (mem_ret.rdata == exp_word))
        else begin
            n_read++;
            $display("mismatch at %0t: read data %h, expected %h", $time,
                     $sampled(mem_ret.rdata), $sampled(exp_word));
        end

    a_delay: assert property (@(posedge clk)
        armed |-> (out_del == exp_out))
        else begin
            n_delay++;
            $display("mismatch at %0t: out_del %b, expected %b", $time,
                     $sampled(out_del), $sampled(exp_out));
        end

    assign errors = n_ack + n_pulse + n_cause + n_held + n_rst + n_read + n_delay;

endmodule

// ==== verif/tb_delay_ctrl.sv ====
/*
 * Testbench for the delay controller
 * Clock, reset, bus driver and stimulus, the checker does the comparing
 */

module tb_delay_ctrl;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int          SIZE = 4;
    localparam logic [31:0] BASE = 32'h4001_0000;  // Control register address

    logic              clk     = 1'b0;
    logic              rst     = 1'b1;
    bus_pkg::mem_fwd_t mem_fwd = '0;
    bus_pkg::mem_ret_t mem_ret;
    logic [SIZE-1:0]   in      = '0;
    logic [SIZE-1:0]   out_del;
    int                errors;         // Checker failures so far
    int                drv_fails = 0;  // Timeouts and unexpected acks
    int                err_mark  = 0;
    int                n_pass    = 0;
    int                n_fail    = 0;
    logic [31:0]       rd_data;

    always #4 clk = ~clk;  // 8 ns period

    delay_ctrl_top #(
        .BASE_ADDR    (8'h40),
        .BASE2_ADDR   (8'h01),
        .SIZE         (SIZE),
        .CALIB_CYCLES (20)
    ) i_dut (
        .clk     (clk),
        .rst     (rst),
        .mem_fwd (mem_fwd),
        .mem_ret (mem_ret),
        .in      (in),
        .out_del (out_del)
    );

    tb_delay_checker #(
        .BASE_ADDR    (8'h40),
        .BASE2_ADDR   (8'h01),
        .SIZE         (SIZE),
        .CALIB_CYCLES (20)
    ) i_chk (
        .clk     (clk),
        .rst     (rst),
        .mem_fwd (mem_fwd),
        .mem_ret (mem_ret),
        .in      (in),
        .out_del (out_del),
        .errors  (errors)
    );

    always @(negedge clk) begin
        in <= SIZE'($urandom());  // Fresh random bits every cycle
    end

    // ------------------------------
    // Bus driver
    // ------------------------------

    // Holds valid until ready, optionally keeps it a few cycles longer
    task automatic bus_cycle(input logic [31:0] addr, input logic [31:0] wdata,
                             input logic [3:0] wstrb, input bit hold,
                             input bit expect_ack, output logic [31:0] rdata);
        int  wait_cnt;
        bit  got;
        wait_cnt = 0;
        got      = 1'b0;
        rdata    = '0;
        @(negedge clk);
        mem_fwd.valid = 1'b1;
        mem_fwd.addr  = addr;
        mem_fwd.wdata = wdata;
        mem_fwd.wstrb = wstrb;
        while (!got && wait_cnt < 50) begin
            @(negedge clk);
            wait_cnt++;
            if (mem_ret.ready) begin
                got   = 1'b1;
                rdata = mem_ret.rdata;   // Stable between edges
            end
        end
        if (got)
            @(negedge clk);              // Access stays up through the ready edge
        if (got && hold)
            repeat (3) @(negedge clk);
        mem_fwd = '0;                    // Drop the access
        if (expect_ack && !got) begin
            drv_fails++;
            $display("bus access to %h got no ready within 50 cycles", addr);
        end else if (!expect_ack && got) begin
            drv_fails++;
            $display("bus access to %h outside the window was acknowledged", addr);
        end
    endtask

    task automatic bus_write(input logic [31:0] wdata, input logic [3:0] wstrb);
        logic [31:0] unused;
        bus_cycle(BASE, wdata, wstrb, 1'b0, 1'b1, unused);
    endtask

    task automatic bus_read(output logic [31:0] rdata);
        bus_cycle(BASE, '0, 4'b0000, 1'b0, 1'b1, rdata);
    endtask

    // One result line per test
    task automatic end_test(input string name);
        int fresh;
        repeat (2) @(negedge clk);       // Let the last assertions fire
        fresh    = errors + drv_fails - err_mark;
        err_mark = errors + drv_fails;
        if (fresh == 0) begin
            n_pass++;
            $display("test %s: pass", name);
        end else begin
            n_fail++;
            $display("test %s: fail with %0d errors", name, fresh);
        end
    endtask

    // ------------------------------
    // Stimulus
    // ------------------------------

    initial begin
        logic [4:0]  taps [SIZE];
        int          seed_val;
        int          polls;
        seed_val = $urandom(32'hc04f5773);
        repeat (16) @(negedge clk);
        rst = 1'b0;

        bus_read(rd_data);               // Still calibrating
        polls = 0;
        while (!rd_data[31] && polls < 40) begin
            bus_read(rd_data);
            polls++;
        end
        if (!rd_data[31]) begin
            drv_fails++;
            $display("ready bit never rose within 40 reads");
        end
        end_test("reset and calibration");

        bus_cycle(BASE, '0, 4'b0000, 1'b1, 1'b1, rd_data);
        bus_cycle(BASE, 32'h0000_0500, 4'b0011, 1'b1, 1'b1, rd_data);
        bus_cycle(BASE ^ 32'h0002_0000, '0, 4'b0000, 1'b0, 1'b0, rd_data);
        bus_cycle(BASE + 32'h4, '0, 4'b0011, 1'b0, 1'b0, rd_data);
        end_test("bus protocol");

        for (int ch = 0; ch < SIZE; ch++) begin
            taps[ch] = 5'($urandom());
            bus_write(($urandom() & 32'hffff_e000) | {19'b0, taps[ch], 8'(ch)}, 4'b1111);
            bus_read(rd_data);
        end
        end_test("tap write and readback");

        taps[0] = 5'd0;
        taps[1] = 5'd31;
        for (int ch = 0; ch < SIZE; ch++)
            bus_write({19'b0, taps[ch], 8'(ch)}, 4'b0011);
        repeat (70) @(negedge clk);      // Long enough for tap 31
        end_test("delay value");

        bus_write({19'b0, 5'd9, 8'd1}, 4'b0011);
        repeat (40) @(negedge clk);
        bus_write({19'b0, ~taps[2], 8'(SIZE + 3)}, 4'b0011);  // No channel there
        bus_read(rd_data);
        bus_write({19'b0, 5'd17, 8'd2}, 4'b0001);             // Sel only
        bus_read(rd_data);
        repeat (40) @(negedge clk);
        end_test("isolation and range");

        $display("tests passed: %0d, tests failed: %0d, checker errors: %0d",
                 n_pass, n_fail, errors);
        if (n_fail == 0 && errors == 0 && drv_fails == 0)
            $display("ALL CHECKS PASSED");
        else
            $display("CHECKS FAILED");
        $finish;
    end

endmodule

// ==== verilog.f ====
design/bus_pkg.sv
design/delay_pkg.sv
design/sfr_regs.sv
design/tap_delay_line.sv
design/delay_calib.sv
design/delay_bank.sv
design/delay_ctrl_top.sv
verif/tb_delay_checker.sv
verif/tb_delay_ctrl.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the delay controller testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --assert -f verilog.f --top-module tb_delay_ctrl \
    -o tb_delay_ctrl > "$BUILD_LOG" 2>&1
status=$?
if [ $status -ne 0 ]; then
    cat "$BUILD_LOG"
    echo "verilator build failed with status $status"
    exit 1
fi

./obj_dir/tb_delay_ctrl > "$SIM_LOG" 2>&1
status=$?
cat "$SIM_LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

# The testbench prints the fail message on any failed check
if grep -q "CHECKS FAILED" "$SIM_LOG"; then
    echo "result: fail"
    exit 1
fi
echo "result: pass"
exit 0
